//--- source/rv_isa_pkg.sv
// RV32I ISA constants
// Opcodes, funct3 and funct7 codes, instruction field positions, reset PC

`default_nettype none

package rv_isa_pkg;

  // Data and address width
  localparam int xlen = 32;

  localparam logic [31:0] reset_pc = 32'h0000_0000;

  // ----------------------------------------------------------------------
  // Instruction field positions (LSB of each field)
  // ----------------------------------------------------------------------
  localparam int opcode_lsb = 0;
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int funct7_lsb = 25;

  // ----------------------------------------------------------------------
  // Major opcodes
  // ----------------------------------------------------------------------
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;

  // Branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // ALU operations, shared by OP and OP-IMM
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Selects SUB and SRA/SRAI
  localparam logic [6:0] f7_alt = 7'b0100000;

endpackage

`default_nettype wire

//--- source/rv_ctl_pkg.sv
// Control path types
// ALU op class and function codes, select enums, control bundle

`default_nettype none

package rv_ctl_pkg;

  // Operation class from the main decoder
  typedef enum logic [1:0] {
    alu_op_add    = 2'd0,
    alu_op_branch = 2'd1,
    alu_op_imm    = 2'd2,
    alu_op_reg    = 2'd3
  } alu_op_t;

  typedef enum logic [4:0] {
    alu_add    = 5'd0,
    alu_sub    = 5'd1,
    alu_sll    = 5'd2,
    alu_slt    = 5'd3,
    alu_sltu   = 5'd4,
    alu_xor    = 5'd5,
    alu_srl    = 5'd6,
    alu_sra    = 5'd7,
    alu_or     = 5'd8,
    alu_and    = 5'd9,
    alu_pass_b = 5'd10
  } alu_fn_t;

  typedef enum logic [2:0] {
    wb_alu = 3'd0,
    wb_mem = 3'd1,
    wb_pc4 = 3'd2,
    wb_imm = 3'd3
  } wb_sel_t;

  typedef enum logic [1:0] {
    npc_inc    = 2'd0,
    npc_branch = 2'd1,
    npc_jal    = 2'd2,
    npc_jalr   = 2'd3
  } next_pc_sel_t;

  // ----------------------------------------------------------------------
  // Control bundle from control path to datapath
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic         pc_write_enable;
    logic         regfile_write_enable;
    logic         alu_operand_a_select;  // 0 rs1, 1 PC
    logic         alu_operand_b_select;  // 0 rs2, 1 immediate
    logic         data_mem_read_enable;
    logic         data_mem_write_enable;
    wb_sel_t      reg_writeback_select;
    next_pc_sel_t next_pc_select;
    alu_fn_t      alu_function;
  } ctl_t;

endpackage

`default_nettype wire

//--- source/singlecycle_control.sv
// Main decoder
// Opcode to control levels, ALU op class and next-PC select

`timescale 1ns/10ps
`default_nettype none

module singlecycle_control (
  input  logic                       clock,
  input  logic [6:0]                 inst_opcode,
  input  logic                       take_branch,
  output logic                       pc_write_enable,
  output logic                       regfile_write_enable,
  output logic                       alu_operand_a_select,
  output logic                       alu_operand_b_select,
  output logic                       data_mem_read_enable,
  output logic                       data_mem_write_enable,
  output rv_ctl_pkg::alu_op_t        alu_op_type,
  output rv_ctl_pkg::wb_sel_t        reg_writeback_select,
  output rv_ctl_pkg::next_pc_sel_t   next_pc_select
);
  import rv_isa_pkg::*;
  import rv_ctl_pkg::*;

  always_comb begin
    // Safe defaults, also used for unknown opcodes
    pc_write_enable       = 1'b1;
    regfile_write_enable  = 1'b0;
    alu_operand_a_select  = 1'b0;
    alu_operand_b_select  = 1'b0;
    data_mem_read_enable  = 1'b0;
    data_mem_write_enable = 1'b0;
    alu_op_type           = alu_op_add;
    reg_writeback_select  = wb_alu;
    next_pc_select        = npc_inc;

    case (inst_opcode)
      opc_lui: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = 1'b1;
        reg_writeback_select = wb_imm;
      end
      opc_auipc: begin
        regfile_write_enable = 1'b1;
        alu_operand_a_select = 1'b1;
        alu_operand_b_select = 1'b1;
      end
      opc_jal: begin
        regfile_write_enable = 1'b1;
        reg_writeback_select = wb_pc4;
        next_pc_select       = npc_jal;
      end
      opc_jalr: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = 1'b1;
        reg_writeback_select = wb_pc4;
        next_pc_select       = npc_jalr;
      end
      opc_branch: begin
        alu_op_type    = alu_op_branch;
        // Not taken falls through to pc+4
        next_pc_select = take_branch ? npc_branch : npc_inc;
      end
      opc_load: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = 1'b1;
        data_mem_read_enable = 1'b1;
        reg_writeback_select = wb_mem;
      end
      opc_store: begin
        alu_operand_b_select  = 1'b1;
        data_mem_write_enable = 1'b1;
      end
      opc_op_imm: begin
        regfile_write_enable = 1'b1;
        alu_operand_b_select = 1'b1;
        alu_op_type          = alu_op_imm;
      end
      opc_op: begin
        regfile_write_enable = 1'b1;
        alu_op_type          = alu_op_reg;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/control_transfer.sv
// Branch condition evaluator
// Decides taken or not taken from funct3 and the ALU zero flag

`timescale 1ns/10ps
`default_nettype none

module control_transfer (
  input  logic       clock,
  input  logic       result_equal_zero,
  input  logic [2:0] inst_funct3,
  output logic       take_branch
);
  import rv_isa_pkg::*;

  // ALU does SUB, SLT or SLTU, so zero means equal or not less
  always_comb begin
    case (inst_funct3)
      f3_beq:  take_branch = result_equal_zero;
      f3_bne:  take_branch = !result_equal_zero;
      f3_blt:  take_branch = !result_equal_zero;
      f3_bge:  take_branch = result_equal_zero;
      f3_bltu: take_branch = !result_equal_zero;
      f3_bgeu: take_branch = result_equal_zero;
      default: take_branch = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/alu_control.sv
// ALU function decoder
// Op class, funct3 and funct7 to ALU function code

`timescale 1ns/10ps
`default_nettype none

module alu_control (
  input  logic                  clock,
  input  rv_ctl_pkg::alu_op_t   alu_op_type,
  input  logic [2:0]            inst_funct3,
  input  logic [6:0]            inst_funct7,
  output rv_ctl_pkg::alu_fn_t   alu_function
);
  import rv_isa_pkg::*;
  import rv_ctl_pkg::*;

  logic is_alt;

  assign is_alt = (inst_funct7 == f7_alt);

  always_comb begin
    alu_function = alu_add;
    case (alu_op_type)
      alu_op_branch: begin
        case (inst_funct3)
          f3_blt, f3_bge:   alu_function = alu_slt;
          f3_bltu, f3_bgeu: alu_function = alu_sltu;
          default:          alu_function = alu_sub;
        endcase
      end
      alu_op_imm, alu_op_reg: begin
        case (inst_funct3)
          // No SUBI, so funct7 only matters for register ops here
          f3_add_sub: alu_function = (alu_op_type == alu_op_reg && is_alt) ? alu_sub : alu_add;
          f3_sll:     alu_function = alu_sll;
          f3_slt:     alu_function = alu_slt;
          f3_sltu:    alu_function = alu_sltu;
          f3_xor:     alu_function = alu_xor;
          f3_srl_sra: alu_function = is_alt ? alu_sra : alu_srl;
          f3_or:      alu_function = alu_or;
          f3_and:     alu_function = alu_and;
          default:    alu_function = alu_add;
        endcase
      end
      default: alu_function = alu_add;
    endcase
  end

endmodule

`default_nettype wire

//--- source/singlecycle_ctlpath.sv
// Control path
// Main decoder, branch evaluator and ALU decoder packed into one bundle

`timescale 1ns/10ps
`default_nettype none

module singlecycle_ctlpath (
  input  logic              clock,
  input  logic [31:0]       inst,
  input  logic              alu_result_equal_zero,
  output rv_ctl_pkg::ctl_t  ctl
);
  import rv_isa_pkg::*;
  import rv_ctl_pkg::*;

  logic [6:0]   inst_opcode;
  logic [2:0]   inst_funct3;
  logic [6:0]   inst_funct7;
  logic         take_branch;
  alu_op_t      alu_op_type;
  alu_fn_t      alu_fn;

  assign inst_opcode = inst[opcode_lsb +: 7];
  assign inst_funct3 = inst[funct3_lsb +: 3];
  assign inst_funct7 = inst[funct7_lsb +: 7];

  // ----------------------------------------------------------------------
  // Decoders
  // ----------------------------------------------------------------------
  control_transfer i_transfer (
    .clock             (clock),
    .result_equal_zero (alu_result_equal_zero),
    .inst_funct3       (inst_funct3),
    .take_branch       (take_branch)
  );

  singlecycle_control i_control (
    .clock                 (clock),
    .inst_opcode           (inst_opcode),
    .take_branch           (take_branch),
    .pc_write_enable       (ctl.pc_write_enable),
    .regfile_write_enable  (ctl.regfile_write_enable),
    .alu_operand_a_select  (ctl.alu_operand_a_select),
    .alu_operand_b_select  (ctl.alu_operand_b_select),
    .data_mem_read_enable  (ctl.data_mem_read_enable),
    .data_mem_write_enable (ctl.data_mem_write_enable),
    .alu_op_type           (alu_op_type),
    .reg_writeback_select  (ctl.reg_writeback_select),
    .next_pc_select        (ctl.next_pc_select)
  );

  alu_control i_alu_ctrl (
    .clock        (clock),
    .alu_op_type  (alu_op_type),
    .inst_funct3  (inst_funct3),
    .inst_funct7  (inst_funct7),
    .alu_function (alu_fn)
  );

  // LUI passes the U immediate straight through operand B
  assign ctl.alu_function = (inst_opcode == opc_lui) ? alu_pass_b : alu_fn;

endmodule

`default_nettype wire

//--- source/singlecycle_datapath.sv
// Datapath
// PC register, register file, immediate generator, ALU,
// operand, writeback and next-PC selection

`timescale 1ns/10ps
`default_nettype none

module singlecycle_datapath (
  input  logic              clock,
  input  logic              rst_n,
  input  logic [31:0]       inst,
  input  rv_ctl_pkg::ctl_t  ctl,
  input  logic [31:0]       data_mem_read_data,
  output logic [31:0]       pc,
  output logic              alu_result_equal_zero,
  output logic              data_mem_read_enable,
  output logic              data_mem_write_enable,
  output logic [31:0]       data_mem_address,
  output logic [31:0]       data_mem_write_data
);
  import rv_isa_pkg::*;
  import rv_ctl_pkg::*;

  logic [6:0]      opcode;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [xlen-1:0] regs [32];
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_next;

  assign opcode = inst[opcode_lsb +: 7];
  assign rd     = inst[rd_lsb +: 5];
  assign rs1    = inst[rs1_lsb +: 5];
  assign rs2    = inst[rs2_lsb +: 5];

  // ----------------------------------------------------------------------
  // Register file, x0 hardwired to zero
  // ----------------------------------------------------------------------
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (ctl.regfile_write_enable && rd != 5'd0) begin
      regs[rd] <= wb_data;
    end
  end

  // Immediate format follows the opcode
  always_comb begin
    case (opcode)
      opc_op_imm, opc_load, opc_jalr: imm = {{20{inst[31]}}, inst[31:20]};
      opc_store:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      opc_branch: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      opc_lui, opc_auipc: imm = {inst[31:12], 12'b0};
      opc_jal:    imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:    imm = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------
  assign op_a = ctl.alu_operand_a_select ? pc : rs1_data;
  assign op_b = ctl.alu_operand_b_select ? imm : rs2_data;

  always_comb begin
    case (ctl.alu_function)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << op_b[4:0];
      alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {31'b0, op_a < op_b};
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> op_b[4:0];
      alu_sra:    alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  assign alu_result_equal_zero = (alu_result == '0);

  // Data memory port
  assign data_mem_read_enable  = ctl.data_mem_read_enable;
  assign data_mem_write_enable = ctl.data_mem_write_enable;
  assign data_mem_address      = alu_result;
  assign data_mem_write_data   = rs2_data;

  // ----------------------------------------------------------------------
  // Writeback and next PC
  // ----------------------------------------------------------------------
  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (ctl.reg_writeback_select)
      wb_mem:  wb_data = data_mem_read_data;
      wb_pc4:  wb_data = pc_plus4;
      wb_imm:  wb_data = imm;
      default: wb_data = alu_result;
    endcase
  end

  // Branch taken already resolved in the control path
  always_comb begin
    case (ctl.next_pc_select)
      npc_branch, npc_jal: pc_next = pc + imm;
      npc_jalr:            pc_next = {alu_result[xlen-1:1], 1'b0};
      default:             pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (ctl.pc_write_enable) begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

//--- source/singlecycle_core.sv
// Single-cycle RV32I core top
// Control path and datapath with instruction and data-memory ports

`timescale 1ns/10ps
`default_nettype none

module singlecycle_core (
  input  logic        clock,
  input  logic        rst_n,
  input  logic [31:0] inst,
  input  logic [31:0] data_mem_read_data,
  output logic [31:0] pc,
  output logic        data_mem_read_enable,
  output logic        data_mem_write_enable,
  output logic [31:0] data_mem_address,
  output logic [31:0] data_mem_write_data
);
  import rv_ctl_pkg::*;

  ctl_t ctl;
  logic alu_result_equal_zero;

  singlecycle_ctlpath i_ctlpath (
    .clock                 (clock),
    .inst                  (inst),
    .alu_result_equal_zero (alu_result_equal_zero),
    .ctl                   (ctl)
  );

  singlecycle_datapath i_datapath (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .inst                  (inst),
    .ctl                   (ctl),
    .data_mem_read_data    (data_mem_read_data),
    .pc                    (pc),
    .alu_result_equal_zero (alu_result_equal_zero),
    .data_mem_read_enable  (data_mem_read_enable),
    .data_mem_write_enable (data_mem_write_enable),
    .data_mem_address      (data_mem_address),
    .data_mem_write_data   (data_mem_write_data)
  );

endmodule

`default_nettype wire

//--- dv/singlecycle_core_props.sv
// Concurrent checks on the core ports
// Memory enables against the opcode, PC alignment, straight-line PC step, reset PC

`timescale 1ns/10ps
`default_nettype none

module singlecycle_core_props (
  input logic        clock,
  input logic        rst_n,
  input logic [31:0] inst,
  input logic [31:0] pc,
  input logic        data_mem_read_enable,
  input logic        data_mem_write_enable
);
  import rv_isa_pkg::*;

  logic [6:0] opcode;
  logic       straight_line;

  assign opcode        = inst[6:0];
  // Opcodes that never redirect the PC
  assign straight_line = opcode inside {opc_lui, opc_auipc, opc_op, opc_op_imm,
                                        opc_load, opc_store};

  // Read only for LW and write only for SW, so never both at once
  mem_enables_match_opcode: assert property (@(posedge clock) disable iff (!rst_n)
    data_mem_read_enable == (opcode == opc_load) &&
    data_mem_write_enable == (opcode == opc_store))
    else $error("data memory enables do not match opcode %h", opcode);

  pc_word_aligned: assert property (@(posedge clock) disable iff (!rst_n)
    pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

  pc_steps_by_four: assert property (@(posedge clock) disable iff (!rst_n)
    straight_line |=> pc == $past(pc) + 32'd4)
    else $error("pc did not advance by 4 after a straight-line instruction");

  pc_after_reset: assert property (@(posedge clock)
    $rose(rst_n) |-> pc == reset_pc)
    else $error("pc not at reset value after reset release: %h", pc);

endmodule

bind singlecycle_core singlecycle_core_props i_props (
  .clock                 (clock),
  .rst_n                 (rst_n),
  .inst                  (inst),
  .pc                    (pc),
  .data_mem_read_enable  (data_mem_read_enable),
  .data_mem_write_enable (data_mem_write_enable)
);

`default_nettype wire

//--- dv/singlecycle_core_tb.sv
// Testbench for the single-cycle RV32I core
// Clock, reset, instruction and data memory models, program builder,
// store checker, watchdog and verdict

`timescale 1ns/10ps
`default_nettype none

module singlecycle_core_tb;
  import rv_isa_pkg::*;

  localparam int clk_period = 40;
  localparam logic [31:0] halt_word = 32'h0000_006f;  // jal x0, 0

  logic        clock;
  logic        rst_n;
  logic [31:0] inst;
  logic [31:0] data_mem_read_data;
  logic [31:0] pc;
  logic        data_mem_read_enable;
  logic        data_mem_write_enable;
  logic [31:0] data_mem_address;
  logic [31:0] data_mem_write_data;

  logic [31:0] imem [128];
  logic [31:0] dmem [64];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          prog_len;
  int          exp_idx;
  bit          prog_ready;
  integer      seed;
  logic [31:0] a;
  logic [31:0] b;
  logic [4:0]  sh;
  logic [31:0] last_pc;
  int          stable;

  singlecycle_core i_singlecycle_core (.*);

  // ----------------------------------------------------------------------
  // Clock and memory models
  // ----------------------------------------------------------------------
  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  assign inst = (pc[31:9] == '0) ? imem[pc[8:2]] : halt_word;

  // Read data only valid while the core reads
  assign data_mem_read_data = data_mem_read_enable ? dmem[data_mem_address[7:2]]
                                                   : 32'hdead_beef;

  always @(posedge clock) begin
    if (data_mem_write_enable) begin
      dmem[data_mem_address[7:2]] <= data_mem_write_data;
    end
  end

  // ----------------------------------------------------------------------
  // Instruction encoders for the ISA formats
  // ----------------------------------------------------------------------
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
  endfunction

  // ----------------------------------------------------------------------
  // Program builder
  // ----------------------------------------------------------------------
  task automatic put(input logic [31:0] word);
    imem[prog_len[6:0]] = word;
    prog_len++;
  endtask

  // SW rs2, off(x0) plus its expected (address, data) entry
  task automatic put_store(input logic [4:0] rs2, input logic [11:0] off,
                           input logic [31:0] data);
    put(enc_s(off, rs2, 5'd0));
    exp_addr.push_back({20'h0, off});
    exp_data.push_back(data);
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [19:0] hi;
    hi = v[31:12] + {19'b0, v[11]};
    put(enc_u(hi, rd, opc_lui));
    put(enc_i(v[11:0], rd, f3_add_sub, rd, opc_op_imm));
  endtask

  // Taken path writes 0x1xx into x10, fall-through writes 0x2xx
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input bit taken,
                             input logic [11:0] off);
    put(enc_b(f3, rs1, rs2, 13'd12));                                 // bxx +12
    put(enc_i(12'h200 | off, 5'd0, f3_add_sub, 5'd10, opc_op_imm));   // addi x10
    put(enc_j(21'd8, 5'd0));                                          // jal x0, +8
    put(enc_i(12'h100 | off, 5'd0, f3_add_sub, 5'd10, opc_op_imm));   // addi x10
    put_store(5'd10, off, taken ? {20'h0, 12'h100 | off} : {20'h0, 12'h200 | off});
  endtask

  task automatic build_program();
    logic [31:0] rnd;
    int          p;
    for (int i = 0; i < 128; i++) begin
      imem[i[6:0]] = halt_word;
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i[5:0]] = 32'h5a5a_0000 ^ i;
    end
    dmem[8] = 32'h1234_5678;
    // Negative a against non-negative b tells SLT from SLTU
    // A nonzero shift of negative a tells SRA from SRL
    a   = $random(seed) | 32'h8000_0000;
    b   = $random(seed) & 32'h7fff_ffff;
    rnd = $random(seed);
    sh  = rnd[4:0] | 5'd1;

    load_const(5'd1, a);                                              // lui/addi x1
    load_const(5'd2, b);                                              // lui/addi x2
    put(enc_i({7'b0, sh}, 5'd0, f3_add_sub, 5'd3, opc_op_imm));       // addi x3, x0, sh
    put(enc_r(7'b0, 5'd2, 5'd1, f3_add_sub, 5'd4));                   // add
    put_store(5'd4, 12'd64, a + b);
    put(enc_r(f7_alt, 5'd2, 5'd1, f3_add_sub, 5'd4));                 // sub
    put_store(5'd4, 12'd68, a - b);
    put(enc_r(f7_alt, 5'd3, 5'd1, f3_srl_sra, 5'd4));                 // sra
    put_store(5'd4, 12'd72, $signed(a) >>> sh);
    put(enc_r(7'b0, 5'd2, 5'd1, f3_slt, 5'd4));                       // slt
    put_store(5'd4, 12'd76, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
    put(enc_r(7'b0, 5'd2, 5'd1, f3_sltu, 5'd4));                      // sltu
    put_store(5'd4, 12'd80, (a < b) ? 32'd1 : 32'd0);
    put(enc_r(7'b0, 5'd3, 5'd1, f3_sll, 5'd4));                       // sll
    put_store(5'd4, 12'd84, a << sh);
    put(enc_i({7'b0, sh}, 5'd1, f3_srl_sra, 5'd4, opc_op_imm));       // srli
    put_store(5'd4, 12'd88, a >> sh);
    put(enc_i(12'h5a5, 5'd1, f3_xor, 5'd4, opc_op_imm));              // xori
    put_store(5'd4, 12'd92, a ^ 32'h0000_05a5);
    put(enc_i(12'h7f0, 5'd2, f3_and, 5'd4, opc_op_imm));              // andi
    put_store(5'd4, 12'd96, b & 32'h0000_07f0);
    put(enc_i(12'hff0, 5'd1, f3_or, 5'd4, opc_op_imm));               // ori
    put_store(5'd4, 12'd100, a | 32'hffff_fff0);

    put(enc_i(12'd32, 5'd0, 3'b010, 5'd5, opc_load));                 // lw x5, 32(x0)
    put(enc_i(12'h111, 5'd5, f3_add_sub, 5'd5, opc_op_imm));          // addi x5
    put_store(5'd5, 12'd104, 32'h1234_5789);
    put_store(5'd2, 12'd108, b);
    put(enc_i(12'd108, 5'd0, 3'b010, 5'd6, opc_load));                // lw x6, 108(x0)
    put_store(5'd6, 12'd112, b);

    put(enc_i(12'hfff, 5'd0, f3_add_sub, 5'd7, opc_op_imm));          // addi x7, x0, -1
    put(enc_i(12'h001, 5'd0, f3_add_sub, 5'd8, opc_op_imm));          // addi x8, x0, 1
    branch_case(f3_beq,  5'd8, 5'd8, 1'b1, 12'd128);
    branch_case(f3_beq,  5'd7, 5'd8, 1'b0, 12'd132);
    branch_case(f3_bne,  5'd7, 5'd8, 1'b1, 12'd136);
    branch_case(f3_bne,  5'd8, 5'd8, 1'b0, 12'd140);
    branch_case(f3_blt,  5'd7, 5'd8, 1'b1, 12'd144);
    branch_case(f3_blt,  5'd8, 5'd7, 1'b0, 12'd148);
    branch_case(f3_bge,  5'd8, 5'd7, 1'b1, 12'd152);
    branch_case(f3_bge,  5'd7, 5'd8, 1'b0, 12'd156);
    branch_case(f3_bltu, 5'd8, 5'd7, 1'b1, 12'd160);
    branch_case(f3_bltu, 5'd7, 5'd8, 1'b0, 12'd164);
    branch_case(f3_bgeu, 5'd7, 5'd8, 1'b1, 12'd168);
    branch_case(f3_bgeu, 5'd8, 5'd7, 1'b0, 12'd172);

    p = prog_len;
    put(enc_j(21'd8, 5'd11));                                         // jal x11, +8
    put(enc_s(12'd200, 5'd7, 5'd0));                                  // skipped sw
    put_store(5'd11, 12'd200, 4 * p + 4);
    p = prog_len;
    put(enc_u(20'h0, 5'd13, opc_auipc));                              // auipc x13, 0
    put_store(5'd13, 12'd204, 4 * p);
    put(enc_i(12'd17, 5'd13, 3'b000, 5'd14, opc_jalr));               // jalr x14, 17(x13)
    put(enc_s(12'd208, 5'd7, 5'd0));                                  // skipped sw
    put_store(5'd14, 12'd208, 4 * p + 12);
    put(enc_u(20'habcde, 5'd16, opc_lui));                            // lui x16
    put_store(5'd16, 12'd212, 32'habcd_e000);
    p = prog_len;
    put(enc_u(20'h00010, 5'd17, opc_auipc));                          // auipc x17
    put_store(5'd17, 12'd216, 32'h0001_0000 + 4 * p);
    put(enc_i(12'h055, 5'd0, f3_add_sub, 5'd0, opc_op_imm));          // addi x0, x0, 0x55
    put_store(5'd0, 12'd220, 32'h0);
  endtask

  // ----------------------------------------------------------------------
  // Checking
  // ----------------------------------------------------------------------
  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_store();
    assert (exp_idx < exp_addr.size()) else begin
      $display("Store to %h after the expected sequence ended", data_mem_address);
      fail_run();
    end
    assert (data_mem_address == exp_addr[exp_idx]) else begin
      $display("[FAIL] data_mem_address expected %h actual %h",
               exp_addr[exp_idx], data_mem_address);
      fail_run();
    end
    assert (data_mem_write_data == exp_data[exp_idx]) else begin
      $display("[FAIL] data_mem_write_data expected %h actual %h",
               exp_data[exp_idx], data_mem_write_data);
      fail_run();
    end
    exp_idx++;
  endtask

  // Combinational outputs settle by mid-cycle
  always @(negedge clock) begin
    if (rst_n && data_mem_write_enable) begin
      check_store();
    end
  end

  initial begin : watchdog
    wait (prog_ready);
    repeat (4 * prog_len + 20) @(posedge clock);
    $display("Timeout: the core never settled in its halt loop");
    fail_run();
  end

  initial begin
    seed       = 32'h9bf7;
    rst_n      = 1'b0;
    prog_len   = 0;
    exp_idx    = 0;
    prog_ready = 1'b0;
    build_program();
    prog_ready = 1'b1;
    repeat (5) @(posedge clock);
    #2 rst_n = 1'b1;
    last_pc = 32'hffff_ffff;
    stable  = 0;
    // Halt loop keeps pc fixed
    while (stable < 3) begin
      @(negedge clock);
      if (pc == last_pc) begin
        stable++;
      end else begin
        stable = 0;
      end
      last_pc = pc;
    end
    if (exp_idx == exp_addr.size()) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Halted after %0d of %0d expected stores", exp_idx, exp_addr.size());
      fail_run();
    end
  end

endmodule

`default_nettype wire

//--- rvsimple.f
source/rv_isa_pkg.sv
source/rv_ctl_pkg.sv
source/singlecycle_control.sv
source/control_transfer.sv
source/alu_control.sv
source/singlecycle_ctlpath.sv
source/singlecycle_datapath.sv
source/singlecycle_core.sv
dv/singlecycle_core_props.sv
dv/singlecycle_core_tb.sv

//--- Makefile
# Verilator build and run for the rvsimple single-cycle core

TOP = singlecycle_core_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f rvsimple.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
